/* hdl/csi2_rx_pkg.sv */
package csi2_rx_pkg;

  // Data identifier sits in the low byte of a header word
  typedef struct packed {
    logic [1:0] vc;
    logic [5:0] dt;
  } csi2_di_t;

  typedef struct packed {
    logic [7:0]  ecc;
    logic [15:0] wc;
    csi2_di_t    di;
  } csi2_long_hdr_t;

  typedef struct packed {
    logic [7:0]  ecc;
    logic [15:0] data;
    csi2_di_t    di;
  } csi2_short_hdr_t;

  typedef union packed {
    csi2_long_hdr_t  long_hdr;
    csi2_short_hdr_t short_hdr;
  } csi2_hdr_t;

  localparam logic [5:0] LONG_DT_MIN = 6'h10;

  // Parity masks over header bits 23..0, P5 first
  localparam logic [5:0][23:0] ECC_MASKS = {
    24'hEFFC00,
    24'hDF03F0,
    24'hB8E38E,
    24'h749A6D,
    24'hF2555B,
    24'hF12CB7
  };

  localparam logic [15:0] CRC_POLY = 16'h8408;
  localparam logic [15:0] CRC_SEED = 16'hFFFF;

  typedef enum logic [1:0] {
    KIND_NONE    = 2'd0,
    KIND_PAYLOAD = 2'd1,
    KIND_CRC     = 2'd2
  } byte_kind_t;

endpackage

/* hdl/csi2_word_if.sv */
`timescale 1ns/100ps

interface csi2_word_if;

  logic [31:0]                   data;
  logic                          valid;
  logic                          hdr;
  csi2_rx_pkg::byte_kind_t [3:0] kind;   // One code per byte lane
  logic                          last;
  logic [2:0]                    nbytes; // Valid bytes in the final word

  modport ctrl (
    output data, valid, hdr, kind, last, nbytes
  );

  modport crc (
    input data, valid, hdr, kind, last
  );

  modport out (
    input data, valid, hdr, last, nbytes
  );

endinterface

/* hdl/csi2_header_ecc.sv */
`timescale 1ns/100ps

module csi2_header_ecc
(
  input  csi2_rx_pkg::csi2_hdr_t hdr_i,
  output csi2_rx_pkg::csi2_hdr_t hdr_o,
  output logic                   corrected_o,
  output logic                   uncorrectable_o
);

logic [23:0] hdr_bits;
logic [5:0]  parity;
logic [5:0]  syndrome;
logic [23:0] flip;
logic        ecc_err;

assign hdr_bits = hdr_i[23:0];

always_comb
  begin
    for( int p = 0; p < 6; p++ )
      parity[p] = ^( hdr_bits & csi2_rx_pkg::ECC_MASKS[p] );
  end

assign syndrome = parity ^ hdr_i.long_hdr.ecc[5:0];

// Each data bit has its own column of weight three or more
always_comb
  begin
    logic [5:0] column;
    flip = '0;
    for( int d = 0; d < 24; d++ )
      begin
        for( int p = 0; p < 6; p++ )
          column[p] = csi2_rx_pkg::ECC_MASKS[p][d];
        if( syndrome == column )
          flip[d] = 1'b1;
      end
  end

assign ecc_err = $onehot( syndrome ); // A lone parity bit was hit

always_comb
  begin
    hdr_o       = hdr_i;
    hdr_o[23:0] = hdr_bits ^ flip;
    if( ecc_err )
      hdr_o.long_hdr.ecc[5:0] = hdr_i.long_hdr.ecc[5:0] ^ syndrome;
  end

assign corrected_o     = ( |flip ) || ecc_err;
assign uncorrectable_o = ( syndrome != 6'd0 ) && !corrected_o;

endmodule

/* hdl/csi2_pkt_ctrl.sv */
`timescale 1ns/100ps

module csi2_pkt_ctrl
(
  input                   clk_i,
  input                   srst_i,
  input        [31:0]     data_i,
  input                   valid_i,
  input                   error_i,
  output logic            phy_rst_o,
  csi2_word_if.ctrl       word_o,
  output logic            short_o,
  output logic            ecc_corr_o
);

csi2_rx_pkg::csi2_hdr_t hdr_fix;
logic                   hdr_corr;
logic                   hdr_bad;
logic                   valid_d1;
logic                   pkt_running;
logic [16:0]            byte_cnt;
logic                   hdr_slot;
logic                   header_valid;
logic                   long_pkt;
logic                   data_word;
logic                   last_word;

csi2_header_ecc header_ecc
(
  .hdr_i           ( data_i   ),
  .hdr_o           ( hdr_fix  ),
  .corrected_o     ( hdr_corr ),
  .uncorrectable_o ( hdr_bad  )
);

// First valid word after a gap while idle
assign hdr_slot     = valid_i && !valid_d1 && !error_i && !pkt_running;
assign header_valid = hdr_slot && !hdr_bad;
assign long_pkt     = header_valid && hdr_fix.long_hdr.di.dt >= csi2_rx_pkg::LONG_DT_MIN;
assign short_o      = header_valid && !long_pkt;
assign data_word    = pkt_running && valid_i && !error_i;
assign last_word    = data_word && byte_cnt <= 17'd4;
assign phy_rst_o    = short_o || last_word || error_i || ( hdr_slot && hdr_bad );

always_ff @( posedge clk_i )
  if( srst_i )
    valid_d1 <= 1'b0;
  else
    valid_d1 <= valid_i;

always_ff @( posedge clk_i )
  if( srst_i )
    pkt_running <= 1'b0;
  else
    if( long_pkt )
      pkt_running <= 1'b1;
    else
      if( phy_rst_o )
        pkt_running <= 1'b0;

// Bytes still to come, footer included
always_ff @( posedge clk_i )
  if( srst_i )
    byte_cnt <= '0;
  else
    if( long_pkt )
      byte_cnt <= 17'( hdr_fix.long_hdr.wc ) + 17'd2;
    else
      if( error_i || last_word )
        byte_cnt <= '0;
      else
        if( data_word )
          byte_cnt <= byte_cnt - 17'd4;

always_ff @( posedge clk_i )
  if( srst_i )
    ecc_corr_o <= 1'b0;
  else
    ecc_corr_o <= header_valid && hdr_corr; // Lines up with the header on the output

assign word_o.data   = header_valid ? hdr_fix : data_i;
assign word_o.valid  = header_valid || data_word;
assign word_o.hdr    = header_valid;
assign word_o.last   = last_word;
assign word_o.nbytes = last_word ? byte_cnt[2:0] : 3'd4;

// The footer is the final two bytes and may straddle two words
always_comb
  begin
    for( int i = 0; i < 4; i++ )
      if( !data_word )
        word_o.kind[i] = csi2_rx_pkg::KIND_NONE;
      else
        if( byte_cnt > 17'( i + 2 ) )
          word_o.kind[i] = csi2_rx_pkg::KIND_PAYLOAD;
        else
          if( byte_cnt > 17'( i ) )
            word_o.kind[i] = csi2_rx_pkg::KIND_CRC;
          else
            word_o.kind[i] = csi2_rx_pkg::KIND_NONE;
  end

endmodule

/* hdl/csi2_payload_crc.sv */
`timescale 1ns/100ps

module csi2_payload_crc
(
  input              clk_i,
  input              srst_i,
  csi2_word_if.crc   word_i,
  output logic       crc_err_o
);

logic [15:0] crc;
logic [15:0] crc_next;
logic [15:0] footer;
logic [15:0] footer_next;

// Reflected CCITT, one byte LSB first
function automatic logic [15:0] crc_byte
(
  input logic [15:0] crc_in,
  input logic [7:0]  byte_in
);
  logic [15:0] c;
  c = crc_in ^ { 8'h00, byte_in };
  for( int k = 0; k < 8; k++ )
    if( c[0] )
      c = ( c >> 1 ) ^ csi2_rx_pkg::CRC_POLY;
    else
      c = c >> 1;
  return c;
endfunction

always_comb
  begin
    crc_next    = crc;
    footer_next = footer;
    for( int i = 0; i < 4; i++ )
      if( word_i.kind[i] == csi2_rx_pkg::KIND_PAYLOAD )
        crc_next = crc_byte( crc_next, word_i.data[8*i +: 8] );
      else
        if( word_i.kind[i] == csi2_rx_pkg::KIND_CRC )
          footer_next = { word_i.data[8*i +: 8], footer_next[15:8] }; // First byte ends up low
  end

always_ff @( posedge clk_i )
  if( word_i.valid )
    if( word_i.hdr )
      crc <= csi2_rx_pkg::CRC_SEED;
    else
      begin
        crc    <= crc_next;
        footer <= footer_next;
      end

always_ff @( posedge clk_i )
  if( srst_i )
    crc_err_o <= 1'b0;
  else
    if( word_i.valid && word_i.last )
      crc_err_o <= crc_next != footer_next;
    else
      crc_err_o <= 1'b0;

endmodule

/* hdl/csi2_axis_out.sv */
`timescale 1ns/100ps

module csi2_axis_out
(
  input               clk_i,
  input               srst_i,
  csi2_word_if.out    word_i,
  input               short_i,
  output logic [31:0] tdata_o,
  output logic        tvalid_o,
  output logic [3:0]  tstrb_o,
  output logic        tlast_o
);

always_ff @( posedge clk_i )
  if( srst_i )
    begin
      tvalid_o <= 1'b0;
      tdata_o  <= '0;
    end
  else
    if( word_i.valid )
      begin
        tvalid_o <= 1'b1;
        tdata_o  <= word_i.data;
      end
    else
      begin
        tvalid_o <= 1'b0;
        tdata_o  <= '0;
      end

// Partial strobe only on the final word of a long packet
always_ff @( posedge clk_i )
  if( srst_i )
    tstrb_o <= '0;
  else
    if( word_i.valid && word_i.last )
      for( int i = 0; i < 4; i++ )
        tstrb_o[i] <= 3'( i ) < word_i.nbytes;
    else
      tstrb_o <= '1;

always_ff @( posedge clk_i )
  if( srst_i )
    tlast_o <= 1'b0;
  else
    if( word_i.valid && ( word_i.last || ( word_i.hdr && short_i ) ) )
      tlast_o <= 1'b1;
    else
      tlast_o <= 1'b0;

endmodule

/* hdl/csi2_rx_packetizer.sv */
`timescale 1ns/100ps

module csi2_rx_packetizer
(
  input               clk_i,
  input               srst_i,
  input        [31:0] data_i,
  input               valid_i,
  input               error_i,
  output logic        phy_rst_o,
  output logic [31:0] tdata_o,
  output logic        tvalid_o,
  output logic [3:0]  tstrb_o,
  output logic        tlast_o,
  output logic        ecc_corr_o,
  output logic        crc_err_o
);

logic short_pkt;

csi2_word_if word_bus();

csi2_pkt_ctrl pkt_ctrl
(
  .clk_i      ( clk_i      ),
  .srst_i     ( srst_i     ),
  .data_i     ( data_i     ),
  .valid_i    ( valid_i    ),
  .error_i    ( error_i    ),
  .phy_rst_o  ( phy_rst_o  ),
  .word_o     ( word_bus   ),
  .short_o    ( short_pkt  ),
  .ecc_corr_o ( ecc_corr_o )
);

csi2_payload_crc payload_crc
(
  .clk_i     ( clk_i     ),
  .srst_i    ( srst_i    ),
  .word_i    ( word_bus  ),
  .crc_err_o ( crc_err_o )
);

csi2_axis_out axis_out
(
  .clk_i    ( clk_i     ),
  .srst_i   ( srst_i    ),
  .word_i   ( word_bus  ),
  .short_i  ( short_pkt ),
  .tdata_o  ( tdata_o   ),
  .tvalid_o ( tvalid_o  ),
  .tstrb_o  ( tstrb_o   ),
  .tlast_o  ( tlast_o   )
);

endmodule

/* test/csi2_rx_assert.sv */
`timescale 1ns/100ps

module csi2_rx_assert
(
  input        clk_i,
  input        srst_i,
  input        phy_rst_o,
  input [31:0] tdata_o,
  input        tvalid_o,
  input [3:0]  tstrb_o,
  input        tlast_o,
  input        ecc_corr_o,
  input        crc_err_o
);

// A partial strobe belongs to the final word only
strb_full: assert property ( @( posedge clk_i ) disable iff ( srst_i )
  !tlast_o && !$past( srst_i ) |-> tstrb_o == 4'hF )
  else $error( "tstrb_o not all ones outside a tlast_o cycle" );

last_valid: assert property ( @( posedge clk_i ) disable iff ( srst_i )
  tlast_o |-> tvalid_o )
  else $error( "tlast_o without tvalid_o" );

crc_on_last: assert property ( @( posedge clk_i ) disable iff ( srst_i )
  crc_err_o |-> tlast_o )
  else $error( "crc_err_o outside a tlast_o cycle" );

reset_quiet: assert property ( @( posedge clk_i ) srst_i |=> !tvalid_o && !tlast_o &&
  tstrb_o == 4'h0 && tdata_o == 32'h0 && !ecc_corr_o && !crc_err_o && !phy_rst_o )
  else $error( "Outputs not cleared by reset" );

endmodule

bind csi2_rx_packetizer csi2_rx_assert csi2_rx_assert_i
(
  .clk_i      ( clk_i      ),
  .srst_i     ( srst_i     ),
  .phy_rst_o  ( phy_rst_o  ),
  .tdata_o    ( tdata_o    ),
  .tvalid_o   ( tvalid_o   ),
  .tstrb_o    ( tstrb_o    ),
  .tlast_o    ( tlast_o    ),
  .ecc_corr_o ( ecc_corr_o ),
  .crc_err_o  ( crc_err_o  )
);

/* test/tb_csi2_rx_packetizer.sv */
`timescale 1ns/100ps

module tb_csi2_rx_packetizer;

typedef struct packed {
  logic [5:0]  dt;
  int          wc;      // Word count, or the data field of a short packet
  logic [31:0] flip;    // Header bits inverted on the way in
  logic        crc_bad;
  int          err_at;  // Word index that raises error_i, -1 for none
} test_row_t;

localparam int NUM_ROWS = 11;
localparam int GAP      = 2;

// CSI-2 header parity equations, P0 first
localparam logic [23:0] PARITY_MASK [6] = '{
  24'hF12CB7, 24'hF2555B, 24'h749A6D, 24'hB8E38E, 24'hDF03F0, 24'hEFFC00
};

logic        clk_i = 1'b0;
logic        srst_i;
logic [31:0] data_i;
logic        valid_i;
logic        error_i;
logic        phy_rst_o;
logic [31:0] tdata_o;
logic        tvalid_o;
logic [3:0]  tstrb_o;
logic        tlast_o;
logic        ecc_corr_o;
logic        crc_err_o;

test_row_t   rows [NUM_ROWS];
logic [15:0] lfsr;
logic        exp_valid;
logic [31:0] exp_data;
logic [3:0]  exp_strb;
logic        exp_last;
logic        exp_corr;
logic        exp_crc_err;
int          errors = 0;
int          row_errors;
int          passed = 0;
int          cycles = 0;
int          cycle_limit;

csi2_rx_packetizer csi2_rx_packetizer_i ( .* );

always #5 clk_i = ~clk_i;

always @( posedge clk_i )
  begin
    cycles <= cycles + 1;
    if( cycles >= cycle_limit )
      begin
        $display( "Timeout after %0d cycles", cycles );
        $display( "** FAIL **" );
        $finish;
      end
  end

function automatic logic [15:0] lfsr_next( input logic [15:0] s );
  return s[0] ? ( ( s >> 1 ) ^ 16'hB400 ) : ( s >> 1 );
endfunction

task automatic rand_byte( output logic [7:0] b );
  for( int k = 0; k < 8; k++ )
    begin
      b[k] = lfsr[0];
      lfsr = lfsr_next( lfsr );
    end
endtask

// Bit-serial reflected CCITT
function automatic logic [15:0] crc_step( input logic [15:0] c, input logic [7:0] b );
  logic fb;
  for( int k = 0; k < 8; k++ )
    begin
      fb = c[0] ^ b[k];
      c  = ( c >> 1 ) ^ ( fb ? 16'h8408 : 16'h0000 );
    end
  return c;
endfunction

function automatic logic [7:0] ecc_of( input logic [23:0] h );
  logic [7:0] e;
  e = 8'h00;
  for( int p = 0; p < 6; p++ )
    e[p] = ^( h & PARITY_MASK[p] );
  return e;
endfunction

task automatic check_value( input string name, input logic [31:0] got, input logic [31:0] exp );
  assert( got === exp )
  else
    begin
      $display( "Mismatch %s: got %h, expected %h", name, got, exp );
      row_errors++;
    end
endtask

// Checks the output of the previous word, then presents the next one
task automatic step( input logic [31:0] data, input logic valid, input logic err,
                     input logic exp_phy );
  @( posedge clk_i );
  #1;
  check_value( "tvalid_o", 32'( tvalid_o ), 32'( exp_valid ) );
  check_value( "tdata_o", tdata_o, exp_data );
  check_value( "tstrb_o", 32'( tstrb_o ), 32'( exp_strb ) );
  check_value( "tlast_o", 32'( tlast_o ), 32'( exp_last ) );
  check_value( "ecc_corr_o", 32'( ecc_corr_o ), 32'( exp_corr ) );
  check_value( "crc_err_o", 32'( crc_err_o ), 32'( exp_crc_err ) );
  data_i  = data;
  valid_i = valid;
  error_i = err;
  #3;
  check_value( "phy_rst_o", 32'( phy_rst_o ), 32'( exp_phy ) );
endtask

task automatic expect_idle();
  exp_valid   = 1'b0;
  exp_data    = 32'h0;
  exp_strb    = 4'hF;
  exp_last    = 1'b0;
  exp_corr    = 1'b0;
  exp_crc_err = 1'b0;
endtask

task automatic idle_cycle();
  step( 32'h0, 1'b0, 1'b0, 1'b0 );
  expect_idle();
endtask

task automatic run_row( input int n, input test_row_t r );
  logic [31:0]            words [$];
  logic [7:0]             bytes [$];
  logic [7:0]             b;
  logic [15:0]            crc;
  csi2_rx_pkg::csi2_hdr_t hdr;
  logic                   is_long;
  logic                   dropped;
  logic                   aborted;
  logic                   last;
  logic                   shown;
  int                     tail;
  is_long = r.dt >= csi2_rx_pkg::LONG_DT_MIN;
  dropped = $countones( r.flip ) > 1; // Double error cannot be corrected
  tail    = ( r.wc + 2 ) % 4;
  crc     = 16'hFFFF;
  hdr     = '0;
  hdr.long_hdr.di.dt = r.dt;
  if( is_long )
    hdr.long_hdr.wc = r.wc[15:0];
  else
    hdr.short_hdr.data = r.wc[15:0];
  hdr.long_hdr.ecc = ecc_of( hdr[23:0] );
  words.push_back( hdr );
  if( is_long )
    begin
      for( int i = 0; i < r.wc; i++ )
        begin
          rand_byte( b );
          crc = crc_step( crc, b );
          bytes.push_back( b );
        end
      if( r.crc_bad )
        crc = crc ^ 16'h0100;
      bytes.push_back( crc[7:0] );  // Footer goes low byte first
      bytes.push_back( crc[15:8] );
      while( bytes.size() % 4 != 0 )
        bytes.push_back( 8'h00 );
      for( int i = 0; i < bytes.size(); i += 4 )
        words.push_back( { bytes[i+3], bytes[i+2], bytes[i+1], bytes[i] } );
    end
  row_errors = 0;
  for( int j = 0; j < words.size(); j++ )
    begin
      last    = j == words.size() - 1;
      aborted = r.err_at >= 0 && j >= r.err_at;
      shown   = !dropped && !aborted;
      step( j == 0 ? words[0] ^ r.flip : words[j], 1'b1, j == r.err_at,
            j == r.err_at || ( dropped ? j == 0 : ( !aborted && last ) ) );
      exp_valid   = shown;
      exp_data    = shown ? words[j] : 32'h0;
      exp_strb    = ( shown && last && is_long && tail != 0 ) ? 4'( ( 1 << tail ) - 1 ) : 4'hF;
      exp_last    = shown && last;
      exp_corr    = shown && j == 0 && $countones( r.flip ) == 1;
      exp_crc_err = shown && last && is_long && r.crc_bad;
    end
  repeat( GAP )
    idle_cycle();
  $display( "Row %0d dt %h wc %0d: %0d errors", n, r.dt, r.wc, row_errors );
  errors += row_errors;
  if( row_errors == 0 )
    passed++;
endtask

initial
  begin
    srst_i     = 1'b1;
    data_i     = 32'h0;
    valid_i    = 1'b0;
    error_i    = 1'b0;
    lfsr       = 16'd6735;
    row_errors = 0;
    expect_idle();
    rows = '{
      '{ 6'h00, 1,  32'h0,        1'b0, -1 },  // Frame start
      '{ 6'h2A, 4,  32'h0,        1'b0, -1 },
      '{ 6'h2A, 5,  32'h0,        1'b0, -1 },
      '{ 6'h2A, 6,  32'h0,        1'b0, -1 },
      '{ 6'h2A, 7,  32'h0,        1'b0, -1 },
      '{ 6'h2A, 8,  32'h00000400, 1'b0, -1 },  // Word count bit hit
      '{ 6'h01, 2,  32'h04000000, 1'b0, -1 },  // ECC field bit hit
      '{ 6'h2A, 6,  32'h00000003, 1'b0, -1 },
      '{ 6'h2A, 12, 32'h0,        1'b1, -1 },
      '{ 6'h2A, 16, 32'h0,        1'b0, 2 },
      '{ 6'h2A, 5,  32'h0,        1'b0, -1 }
    };
    cycle_limit = 12;
    foreach( rows[i] )
      begin
        cycle_limit += 1 + GAP;
        if( rows[i].dt >= csi2_rx_pkg::LONG_DT_MIN )
          cycle_limit += ( rows[i].wc + 5 ) / 4;
      end
    cycle_limit *= 2;
    repeat( 10 ) @( posedge clk_i );
    #1;
    srst_i = 1'b0;
    idle_cycle();
    idle_cycle();
    idle_cycle();
    errors += row_errors;
    for( int n = 0; n < NUM_ROWS; n++ )
      run_row( n, rows[n] );
    $display( "Rows %0d, passed %0d, failed %0d, errors %0d",
              NUM_ROWS, passed, NUM_ROWS - passed, errors );
    if( errors == 0 )
      $display( "** PASS **" );
    else
      $display( "** FAIL **" );
    $finish;
  end

endmodule

/* csi2_rx_packetizer.f */
hdl/csi2_rx_pkg.sv
hdl/csi2_word_if.sv
hdl/csi2_header_ecc.sv
hdl/csi2_pkt_ctrl.sv
hdl/csi2_payload_crc.sv
hdl/csi2_axis_out.sv
hdl/csi2_rx_packetizer.sv
test/csi2_rx_assert.sv
test/tb_csi2_rx_packetizer.sv

/* Makefile */
VERILATOR  = verilator
FLAGS      = --timing --assert
TOP        = tb_csi2_rx_packetizer
FILELIST   = csi2_rx_packetizer.f
BUILD_DIR  = obj_dir
PASS_TEXT  = ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
